/* rtl/game_pkg.sv */
package game_pkg;

	// Score format
	localparam int score_w  = 14;                                   // Holds up to 9999
	localparam int digits_w = 16;                                   // Four BCD digits
	localparam logic [score_w-1:0] score_max  = 14'd9999;           // Saturation value
	localparam logic [score_w-1:0] hit_points = 14'd10;             // Points per hit

	// Infrared reading
	localparam int ir_w = 16;
	localparam logic [ir_w-1:0] hit_threshold = 16'h8000;           // At or above means aimed

	// Screen phases
	localparam int screen_w = 3;
	localparam logic [screen_w-1:0] screen_logo     = 3'd0;
	localparam logic [screen_w-1:0] screen_ready    = 3'd1;
	localparam logic [screen_w-1:0] screen_play     = 3'd2;
	localparam logic [screen_w-1:0] screen_times_up = 3'd3;
	localparam logic [screen_w-1:0] screen_board    = 3'd4;         // Held until reset or get_ready

	// Phase lengths in clock cycles
	localparam int timer_w = 12;                                    // Must hold play_cycles
	localparam logic [timer_w-1:0] logo_cycles     = 12'd64;
	localparam logic [timer_w-1:0] ready_cycles    = 12'd64;
	localparam logic [timer_w-1:0] play_cycles     = 12'd2048;
	localparam logic [timer_w-1:0] times_up_cycles = 12'd64;

	// House codes
	localparam int house_w = 2;
	localparam logic [house_w-1:0] house_gryffindor = 2'd0;
	localparam logic [house_w-1:0] house_slytherin  = 2'd1;
	localparam logic [house_w-1:0] house_hufflepuff = 2'd2;
	localparam logic [house_w-1:0] house_ravenclaw  = 2'd3;

endpackage

/* rtl/video_pkg.sv */
package video_pkg;

	localparam int coord_w = 10;                                    // Counter and coordinate width

	// Horizontal timing in pixels
	localparam logic [coord_w-1:0] h_visible = 10'd640;
	localparam logic [coord_w-1:0] h_front   = 10'd16;
	localparam logic [coord_w-1:0] h_sync    = 10'd96;
	localparam logic [coord_w-1:0] h_back    = 10'd48;
	localparam logic [coord_w-1:0] h_total   = h_visible + h_front + h_sync + h_back; // 800

	// Vertical timing in lines
	localparam logic [coord_w-1:0] v_visible = 10'd480;
	localparam logic [coord_w-1:0] v_front   = 10'd10;
	localparam logic [coord_w-1:0] v_sync    = 10'd2;
	localparam logic [coord_w-1:0] v_back    = 10'd33;
	localparam logic [coord_w-1:0] v_total   = v_visible + v_front + v_sync + v_back; // 525

	localparam int color_w = 8;                                     // Per channel
	localparam logic [coord_w-1:0] band_height = 10'd64;            // House band lines

	// Palette, RGB packed red highest
	localparam logic [3*color_w-1:0] colour_house_0    = 24'h740001; // Gryffindor scarlet
	localparam logic [3*color_w-1:0] colour_house_1    = 24'h1a472a; // Slytherin green
	localparam logic [3*color_w-1:0] colour_house_2    = 24'hffd800; // Hufflepuff yellow
	localparam logic [3*color_w-1:0] colour_house_3    = 24'h0e1a40; // Ravenclaw blue
	localparam logic [3*color_w-1:0] colour_ready      = 24'h2e8b57;
	localparam logic [3*color_w-1:0] colour_times_up   = 24'hb22222;
	localparam logic [3*color_w-1:0] colour_board      = 24'h4b0082;
	localparam logic [3*color_w-1:0] colour_background = 24'h101010;

endpackage

/* rtl/score_calc.sv */
module score_calc (
	input  logic                         clock,
	input  logic                         reset,
	input  logic [game_pkg::ir_w-1:0]    ir_in,
	input  logic                         scoring,   // High only while hits count
	input  logic                         clear,     // Restart from zero
	output logic [game_pkg::score_w-1:0] score
);

	logic aimed;       // Current sample over threshold
	logic aimed_q;     // Previous sample over threshold
	logic hit;
	logic at_ceiling;  // One more hit would pass the maximum

	assign aimed = ir_in >= game_pkg::hit_threshold;
	assign hit   = scoring && aimed && !aimed_q;                    // Rising crossing only

	// Held readings give one hit; a reading that stays aimed never scores again
	assign at_ceiling = score > (game_pkg::score_max - game_pkg::hit_points);

	always_ff @(posedge clock) begin
		if (reset) begin
			aimed_q <= 1'b0;
			score   <= '0;
		end else begin
			aimed_q <= aimed;                                       // Tracked even outside play
			if (clear) begin
				score <= '0;
			end else if (hit) begin
				if (at_ceiling) begin
					score <= game_pkg::score_max;                   // Saturate
				end else begin
					score <= score + game_pkg::hit_points;
				end
			end
		end
	end

endmodule

/* rtl/score_to_digits.sv */
module score_to_digits (
	input  logic                          clock,
	input  logic                          reset,
	input  logic [game_pkg::score_w-1:0]  score,
	output logic [game_pkg::digits_w-1:0] digits   // Thousands in top nibble
);

	logic [3:0]                    cnt;        // 0 loads, 1..14 shift
	logic [game_pkg::digits_w-1:0] bcd;        // Partial BCD result
	logic [game_pkg::digits_w-1:0] bcd_adj;    // After add-3 correction
	logic [game_pkg::digits_w-1:0] bcd_next;
	logic [game_pkg::score_w-1:0]  bin;        // Binary bits still to shift in
	logic [game_pkg::score_w-1:0]  bin_next;
	logic                          pass_last;

	// Correct one digit before it doubles
	function automatic logic [3:0] add3(input logic [3:0] d);
		return (d >= 4'd5) ? d + 4'd3 : d;
	endfunction

	assign bcd_adj = {add3(bcd[15:12]), add3(bcd[11:8]), add3(bcd[7:4]), add3(bcd[3:0])};

	// One left shift across the BCD and binary halves
	assign bcd_next  = {bcd_adj[game_pkg::digits_w-2:0], bin[game_pkg::score_w-1]};
	assign bin_next  = {bin[game_pkg::score_w-2:0], 1'b0};
	assign pass_last = cnt == 4'(game_pkg::score_w);                // One shift per score bit

	always_ff @(posedge clock) begin
		if (reset) begin
			cnt    <= '0;
			digits <= '0;
		end else begin
			cnt <= pass_last ? 4'd0 : cnt + 4'd1;                   // Free running pass
			if (pass_last) begin
				digits <= bcd_next;                                 // Final shift lands here
			end
		end
	end

	// Shift datapath reloads at the start of every pass
	always_ff @(posedge clock) begin
		if (cnt == 4'd0) begin
			bcd <= '0;
			bin <= score;                                           // Sample once per pass
		end else begin
			bcd <= bcd_next;
			bin <= bin_next;
		end
	end

endmodule

/* rtl/screen_timer.sv */
module screen_timer (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          leaderboard,   // Host jump to board
	input  logic                          get_ready,     // Host restart of a round
	output logic [game_pkg::screen_w-1:0] screen,
	output logic                          score_clear    // First cycle of ready
);

	logic [game_pkg::timer_w-1:0]  cnt;          // Cycles spent in this phase
	logic [game_pkg::timer_w-1:0]  cnt_next;
	logic [game_pkg::timer_w-1:0]  phase_len;
	logic [game_pkg::screen_w-1:0] next_screen;
	logic                          phase_done;
	logic                          phase_change;
	logic                          clear_scores;

	always_comb begin
		case (screen)
			game_pkg::screen_logo:     phase_len = game_pkg::logo_cycles;
			game_pkg::screen_ready:    phase_len = game_pkg::ready_cycles;
			game_pkg::screen_play:     phase_len = game_pkg::play_cycles;
			game_pkg::screen_times_up: phase_len = game_pkg::times_up_cycles;
			default:                   phase_len = '0;          // Board never times out
		endcase
	end

	assign cnt_next   = cnt + 1'b1;
	assign phase_done = (phase_len != '0) && (cnt_next == phase_len);

	always_comb begin
		next_screen = screen;
		if (get_ready) begin
			next_screen = game_pkg::screen_ready;                   // Host request wins
		end else if (leaderboard) begin
			next_screen = game_pkg::screen_board;
		end else if (phase_done) begin
			case (screen)
				game_pkg::screen_logo:     next_screen = game_pkg::screen_ready;
				game_pkg::screen_ready:    next_screen = game_pkg::screen_play;
				game_pkg::screen_play:     next_screen = game_pkg::screen_times_up;
				game_pkg::screen_times_up: next_screen = game_pkg::screen_board;
				default:                   next_screen = screen;
			endcase
		end
	end

	assign phase_change = (next_screen != screen) || get_ready;    // get_ready restarts ready
	assign clear_scores = phase_change && (next_screen == game_pkg::screen_ready);

	always_ff @(posedge clock) begin
		if (reset) begin
			screen      <= game_pkg::screen_logo;
			cnt         <= '0;
			score_clear <= 1'b0;
		end else begin
			screen      <= next_screen;
			score_clear <= clear_scores;                            // One cycle pulse
			if (phase_change) begin
				cnt <= '0;                                          // Reload on every change
			end else if (screen != game_pkg::screen_board) begin
				cnt <= cnt_next;
			end
		end
	end

endmodule

/* rtl/vga_timing.sv */
module vga_timing (
	input  logic                          clock,
	input  logic                          reset,
	output logic                          hs,      // Active low
	output logic                          vs,      // Active low
	output logic                          blank,   // High outside the visible area
	output logic [video_pkg::coord_w-1:0] x,
	output logic [video_pkg::coord_w-1:0] y
);

	logic [video_pkg::coord_w-1:0] h_cnt;
	logic [video_pkg::coord_w-1:0] v_cnt;
	logic                          h_last;     // Last pixel of a line
	logic                          v_last;     // Last line of a frame
	logic                          h_in_sync;
	logic                          v_in_sync;
	logic                          visible;

	assign h_last = h_cnt == (video_pkg::h_total - 1'b1);
	assign v_last = v_cnt == (video_pkg::v_total - 1'b1);

	// Sync starts after visible area plus front porch
	assign h_in_sync = (h_cnt >= video_pkg::h_visible + video_pkg::h_front) &&
		(h_cnt < video_pkg::h_visible + video_pkg::h_front + video_pkg::h_sync);
	assign v_in_sync = (v_cnt >= video_pkg::v_visible + video_pkg::v_front) &&
		(v_cnt < video_pkg::v_visible + video_pkg::v_front + video_pkg::v_sync);
	assign visible = (h_cnt < video_pkg::h_visible) && (v_cnt < video_pkg::v_visible);

	always_ff @(posedge clock) begin
		if (reset) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else begin
			h_cnt <= h_last ? '0 : h_cnt + 1'b1;
			if (h_last) begin
				v_cnt <= v_last ? '0 : v_cnt + 1'b1;                // Step once per line
			end
		end
	end

	// Outputs lag the counters by one cycle, x and y lag with them
	always_ff @(posedge clock) begin
		if (reset) begin
			hs    <= 1'b1;
			vs    <= 1'b1;
			blank <= 1'b1;
			x     <= '0;
			y     <= '0;
		end else begin
			hs    <= !h_in_sync;
			vs    <= !v_in_sync;
			blank <= !visible;
			x     <= h_cnt;
			y     <= v_cnt;
		end
	end

endmodule

/* rtl/pixel_painter.sv */
module pixel_painter (
	input  logic                          clock,
	input  logic                          reset,
	input  logic                          hs,
	input  logic                          vs,
	input  logic                          blank,
	input  logic [video_pkg::coord_w-1:0] x,
	input  logic [video_pkg::coord_w-1:0] y,
	input  logic [game_pkg::house_w-1:0]  house_p1,
	input  logic [game_pkg::house_w-1:0]  house_p2,
	input  logic                          two_player_mode,
	input  logic [game_pkg::screen_w-1:0] screen,
	output logic                          vga_hs,
	output logic                          vga_vs,
	output logic                          vga_blank,
	output logic [video_pkg::color_w-1:0] vga_r,
	output logic [video_pkg::color_w-1:0] vga_g,
	output logic [video_pkg::color_w-1:0] vga_b
);

	logic [3*video_pkg::color_w-1:0] colour;     // Packed RGB for this pixel
	logic                            in_band;    // Top house band
	logic                            left_half;

	// House code to palette entry
	function automatic logic [3*video_pkg::color_w-1:0] house_colour(
		input logic [game_pkg::house_w-1:0] house
	);
		case (house)
			game_pkg::house_gryffindor: house_colour = video_pkg::colour_house_0;
			game_pkg::house_slytherin:  house_colour = video_pkg::colour_house_1;
			game_pkg::house_hufflepuff: house_colour = video_pkg::colour_house_2;
			default:                    house_colour = video_pkg::colour_house_3; // Ravenclaw
		endcase
	endfunction

	assign in_band   = y < video_pkg::band_height;
	assign left_half = x < (video_pkg::h_visible >> 1);

	always_comb begin
		case (screen)
			game_pkg::screen_play: begin
				if (!in_band) begin
					colour = video_pkg::colour_background;
				end else if (left_half) begin
					colour = house_colour(house_p1);
				end else if (two_player_mode) begin
					colour = house_colour(house_p2);
				end else begin
					colour = video_pkg::colour_background;          // Single player
				end
			end
			game_pkg::screen_ready:    colour = video_pkg::colour_ready;
			game_pkg::screen_times_up: colour = video_pkg::colour_times_up;
			game_pkg::screen_board:    colour = video_pkg::colour_board;
			default:                   colour = video_pkg::colour_background; // Logo
		endcase
	end

	// One stage for sync, blank and colour together
	always_ff @(posedge clock) begin
		if (reset) begin
			vga_hs    <= 1'b1;
			vga_vs    <= 1'b1;
			vga_blank <= 1'b1;
			{vga_r, vga_g, vga_b} <= '0;
		end else begin
			vga_hs    <= hs;
			vga_vs    <= vs;
			vga_blank <= blank;
			{vga_r, vga_g, vga_b} <= blank ? '0 : colour;          // Black in blanking
		end
	end

endmodule

/* rtl/graphics.sv */
module graphics (
	input  logic                          clock,
	input  logic                          reset,
	input  logic [game_pkg::ir_w-1:0]     ir_in_p1,
	input  logic [game_pkg::ir_w-1:0]     ir_in_p2,
	input  logic [game_pkg::house_w-1:0]  house_p1,
	input  logic [game_pkg::house_w-1:0]  house_p2,
	input  logic                          two_player_mode,
	input  logic                          leaderboard,
	input  logic                          get_ready,
	output logic                          vga_hs,
	output logic                          vga_vs,
	output logic                          vga_blank,
	output logic [video_pkg::color_w-1:0] vga_r,
	output logic [video_pkg::color_w-1:0] vga_g,
	output logic [video_pkg::color_w-1:0] vga_b,
	output logic [game_pkg::digits_w-1:0] p1_digits,   // To seven-segment
	output logic [game_pkg::digits_w-1:0] p2_digits,
	output logic [game_pkg::screen_w-1:0] screen       // Phase for the host
);

	logic [game_pkg::score_w-1:0]  p1_score;
	logic [game_pkg::score_w-1:0]  p2_score;
	logic                          score_clear;   // Entry to ready
	logic                          scoring_p1;
	logic                          scoring_p2;
	logic                          hs;
	logic                          vs;
	logic                          blank;
	logic [video_pkg::coord_w-1:0] x;
	logic [video_pkg::coord_w-1:0] y;

	assign scoring_p1 = screen == game_pkg::screen_play;
	assign scoring_p2 = scoring_p1 && two_player_mode;             // P2 idle in single mode

	screen_timer i_screen_timer (.clock(clock), .reset(reset), .leaderboard(leaderboard),
		.get_ready(get_ready), .screen(screen), .score_clear(score_clear));

	score_calc i_score_p1 (.clock(clock), .reset(reset), .ir_in(ir_in_p1),
		.scoring(scoring_p1), .clear(score_clear), .score(p1_score));
	score_calc i_score_p2 (.clock(clock), .reset(reset), .ir_in(ir_in_p2),
		.scoring(scoring_p2), .clear(score_clear), .score(p2_score));

	score_to_digits i_digits_p1 (.clock(clock), .reset(reset), .score(p1_score),
		.digits(p1_digits));
	score_to_digits i_digits_p2 (.clock(clock), .reset(reset), .score(p2_score),
		.digits(p2_digits));

	vga_timing i_vga_timing (.clock(clock), .reset(reset), .hs(hs), .vs(vs),
		.blank(blank), .x(x), .y(y));

	pixel_painter i_pixel_painter (.clock(clock), .reset(reset), .hs(hs), .vs(vs),
		.blank(blank), .x(x), .y(y), .house_p1(house_p1), .house_p2(house_p2),
		.two_player_mode(two_player_mode), .screen(screen), .vga_hs(vga_hs),
		.vga_vs(vga_vs), .vga_blank(vga_blank), .vga_r(vga_r), .vga_g(vga_g),
		.vga_b(vga_b));

endmodule

/* tb/graphics_properties.sv */
module graphics_properties (
	input logic                          clock,
	input logic                          reset,
	input logic                          vga_hs,
	input logic                          vga_vs,
	input logic                          vga_blank,
	input logic [video_pkg::color_w-1:0] vga_r,
	input logic [video_pkg::color_w-1:0] vga_g,
	input logic [video_pkg::color_w-1:0] vga_b
);

	int hs_low;   // Consecutive low cycles
	int vs_low;

	always_ff @(posedge clock) begin
		if (reset) begin
			hs_low <= 0;
			vs_low <= 0;
		end else begin
			hs_low <= vga_hs ? 0 : hs_low + 1;
			vs_low <= vga_vs ? 0 : vs_low + 1;
		end
	end

	blank_black: assert property (@(posedge clock) disable iff (reset)
		vga_blank |-> (vga_r == '0 && vga_g == '0 && vga_b == '0))
		else $error("colour not black during blank");

	hs_width: assert property (@(posedge clock) disable iff (reset)
		$rose(vga_hs) |-> hs_low == int'(video_pkg::h_sync))
		else $error("hsync pulse width wrong");

	vs_width: assert property (@(posedge clock) disable iff (reset)
		$rose(vga_vs) |-> vs_low == int'(video_pkg::v_sync) * int'(video_pkg::h_total))
		else $error("vsync pulse width wrong");

endmodule

/* tb/graphics_tb.sv */
module graphics_tb;

	localparam int n_fields     = 11;                         // Columns per stimulus row
	localparam int max_steps    = 64;
	localparam int settle       = 32;                         // Digit latency bound
	localparam int reset_cycles = 8;
	localparam int frame_cycles = int'(video_pkg::h_total) * int'(video_pkg::v_total);

	logic                          clock;
	logic                          reset;
	logic [game_pkg::ir_w-1:0]     ir_in_p1;
	logic [game_pkg::ir_w-1:0]     ir_in_p2;
	logic [game_pkg::house_w-1:0]  house_p1;
	logic [game_pkg::house_w-1:0]  house_p2;
	logic                          two_player_mode;
	logic                          leaderboard;
	logic                          get_ready;
	logic                          vga_hs;
	logic                          vga_vs;
	logic                          vga_blank;
	logic [video_pkg::color_w-1:0] vga_r;
	logic [video_pkg::color_w-1:0] vga_g;
	logic [video_pkg::color_w-1:0] vga_b;
	logic [game_pkg::digits_w-1:0] p1_digits;
	logic [game_pkg::digits_w-1:0] p2_digits;
	logic [game_pkg::screen_w-1:0] screen;

	logic [31:0] stim [0:n_fields*max_steps-1];               // Rows laid end to end
	int          n_steps;
	int          total_hold;
	bit          loaded;
	int          errors;
	int          checks;

	logic [game_pkg::screen_w-1:0] ref_phase;                 // Model phase after the rising edge
	logic [game_pkg::screen_w-1:0] ref_phase_q;               // Phase the painter just used
	logic [game_pkg::house_w-1:0]  ref_house_q;
	int                            ref_age;
	int                            ref_p1;
	int                            ref_p2;
	bit                            ref_aimed1;
	bit                            ref_aimed2;

	int hs_low;
	int hs_period;
	int hs_pulses;
	int vs_low;
	int vs_pulses;
	int vis_run;                                              // Visible pixels in this line
	int frame_checks;
	bit frame_armed = 1'b1;                                   // Next visible pixel starts a frame

	graphics i_dut (.clock(clock), .reset(reset), .ir_in_p1(ir_in_p1), .ir_in_p2(ir_in_p2),
		.house_p1(house_p1), .house_p2(house_p2), .two_player_mode(two_player_mode),
		.leaderboard(leaderboard), .get_ready(get_ready), .vga_hs(vga_hs), .vga_vs(vga_vs),
		.vga_blank(vga_blank), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.p1_digits(p1_digits), .p2_digits(p2_digits), .screen(screen));

	bind pixel_painter graphics_properties i_properties (.clock(clock), .reset(reset),
		.vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank(vga_blank), .vga_r(vga_r),
		.vga_g(vga_g), .vga_b(vga_b));

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("error at %0t: %s got %0h expected %0h", $time, what, got, want);
		end
	endtask

	// Fill word that no 16-bit first field can match
	function automatic logic [31:0] unread_word(input int index);
		return {16'hffff, 16'(index)};
	endfunction

	function automatic logic [15:0] to_decimal(input int value);
		return {4'(value / 1000 % 10), 4'(value / 100 % 10), 4'(value / 10 % 10),
			4'(value % 10)};
	endfunction

	function automatic int add_hit(input int score);
		int sum;
		sum = score + int'(game_pkg::hit_points);
		return (sum > int'(game_pkg::score_max)) ? int'(game_pkg::score_max) : sum;
	endfunction

	function automatic int phase_length(input logic [game_pkg::screen_w-1:0] phase);
		case (phase)
			game_pkg::screen_logo:     return int'(game_pkg::logo_cycles);
			game_pkg::screen_ready:    return int'(game_pkg::ready_cycles);
			game_pkg::screen_play:     return int'(game_pkg::play_cycles);
			game_pkg::screen_times_up: return int'(game_pkg::times_up_cycles);
			default:                   return 0;              // Board has no end
		endcase
	endfunction

	function automatic logic [game_pkg::screen_w-1:0] following_phase(
		input logic [game_pkg::screen_w-1:0] phase);
		case (phase)
			game_pkg::screen_logo:  return game_pkg::screen_ready;
			game_pkg::screen_ready: return game_pkg::screen_play;
			game_pkg::screen_play:  return game_pkg::screen_times_up;
			default:                return game_pkg::screen_board;
		endcase
	endfunction

	// Colour of pixel (0, 0) in a phase, which lies in the player 1 half
	function automatic logic [23:0] first_pixel_colour(input logic [2:0] phase,
		input logic [1:0] house);
		case (phase)
			game_pkg::screen_play: begin
				case (house)
					game_pkg::house_gryffindor: return video_pkg::colour_house_0;
					game_pkg::house_slytherin:  return video_pkg::colour_house_1;
					game_pkg::house_hufflepuff: return video_pkg::colour_house_2;
					default:                    return video_pkg::colour_house_3;
				endcase
			end
			game_pkg::screen_ready:    return video_pkg::colour_ready;
			game_pkg::screen_times_up: return video_pkg::colour_times_up;
			game_pkg::screen_board:    return video_pkg::colour_board;
			default:                   return video_pkg::colour_background;
		endcase
	endfunction

	initial begin : clock_gen
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin : stimulus
		int i;
		int base;
		int hold;
		reset           = 1'b1;
		ir_in_p1        = '0;
		ir_in_p2        = '0;
		house_p1        = '0;
		house_p2        = '0;
		two_player_mode = 1'b0;
		leaderboard     = 1'b0;
		get_ready       = 1'b0;
		for (i = 0; i < n_fields * max_steps; i++) begin
			stim[i] = unread_word(i);                         // Marks words the file left alone
		end
		$readmemh("tb/stim_input.txt", stim);
		n_steps    = 0;
		total_hold = 0;
		while (n_steps < max_steps &&
			stim[n_steps * n_fields] != unread_word(n_steps * n_fields)) begin
			total_hold += int'(stim[n_steps * n_fields + 7]);
			n_steps++;
		end
		if (n_steps == 0) begin
			errors++;
			$display("no stimulus rows were read from tb/stim_input.txt");
		end
		loaded = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (i = 0; i < n_steps; i++) begin
			base            = i * n_fields;
			ir_in_p1        = stim[base][15:0];
			ir_in_p2        = stim[base+1][15:0];
			house_p1        = stim[base+2][1:0];
			house_p2        = stim[base+3][1:0];
			two_player_mode = stim[base+4][0];
			leaderboard     = stim[base+5][0];                // Pulse rows hold one cycle
			get_ready       = stim[base+6][0];
			hold            = int'(stim[base+7]);
			repeat (hold) @(negedge clock);
			check_value($sformatf("step %0d model phase", i), ref_phase, stim[base+10]);
			check_value($sformatf("step %0d screen", i), screen, stim[base+10]);
			check_value($sformatf("step %0d model p1", i), to_decimal(ref_p1), stim[base+8]);
			check_value($sformatf("step %0d model p2", i), to_decimal(ref_p2), stim[base+9]);
			if (hold >= settle) begin                         // Digits only after a settle
				check_value($sformatf("step %0d p1_digits", i), p1_digits, stim[base+8]);
				check_value($sformatf("step %0d p2_digits", i), p2_digits, stim[base+9]);
			end
		end
		check_value("frame start pixels checked", frame_checks, 2);
		check_value("vsync pulses seen", vs_pulses, 1);
		check_value("hsync seen", hs_pulses != 0, 1);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Phase and score model from the game rules
	always @(posedge clock) begin : ref_model
		bit aimed1;
		bit aimed2;
		aimed1      = ir_in_p1 >= game_pkg::hit_threshold;
		aimed2      = ir_in_p2 >= game_pkg::hit_threshold;
		ref_phase_q = ref_phase;
		ref_house_q = house_p1;
		if (reset) begin
			ref_phase  = game_pkg::screen_logo;
			ref_age    = 0;
			ref_p1     = 0;
			ref_p2     = 0;
			ref_aimed1 = 1'b0;
			ref_aimed2 = 1'b0;
		end else begin
			if (ref_phase == game_pkg::screen_play) begin
				if (aimed1 && !ref_aimed1) begin
					ref_p1 = add_hit(ref_p1);
				end
				if (aimed2 && !ref_aimed2 && two_player_mode) begin
					ref_p2 = add_hit(ref_p2);
				end
			end
			ref_aimed1 = aimed1;
			ref_aimed2 = aimed2;
			if (get_ready) begin
				ref_phase = game_pkg::screen_ready;
				ref_age   = 0;
			end else if (leaderboard) begin
				ref_phase = game_pkg::screen_board;
				ref_age   = 0;
			end else if (ref_age + 1 == phase_length(ref_phase)) begin
				ref_phase = following_phase(ref_phase);
				ref_age   = 0;
			end else begin
				ref_age++;
			end
			if (ref_phase == game_pkg::screen_ready && ref_age == 0) begin
				ref_p1 = 0;                                   // Entry to ready
				ref_p2 = 0;
			end
		end
	end

	always @(negedge clock) begin : raster_monitor
		if (vga_blank) begin
			check_value("colour during blank", {vga_r, vga_g, vga_b}, 24'h0);
		end
		if (!vga_blank) begin
			vis_run++;
		end else if (vis_run != 0) begin
			check_value("visible pixels per line", vis_run, video_pkg::h_visible);
			vis_run = 0;
		end
		hs_period++;
		if (!vga_hs) begin
			if (hs_low == 0) begin                            // Falling edge
				if (hs_pulses != 0) begin
					check_value("hsync period", hs_period, video_pkg::h_total);
				end
				hs_period = 0;
			end
			hs_low++;
		end else if (hs_low != 0) begin
			check_value("hsync low width", hs_low, video_pkg::h_sync);
			hs_pulses++;
			hs_low = 0;
		end
		if (!vga_vs) begin
			vs_low++;
			frame_armed = 1'b1;
		end else if (vs_low != 0) begin
			check_value("vsync low width", vs_low,
				int'(video_pkg::v_sync) * int'(video_pkg::h_total));
			vs_pulses++;
			vs_low = 0;
		end
		if (frame_armed && vga_blank == 1'b0) begin
			check_value("first visible pixel", {vga_r, vga_g, vga_b},
				first_pixel_colour(ref_phase_q, ref_house_q));
			frame_checks++;
			frame_armed = 1'b0;
		end
	end

	initial begin : watchdog
		wait (loaded);
		repeat (reset_cycles + total_hold + 2 * frame_cycles) @(posedge clock);
		$display("timeout: the stimulus did not finish in the expected number of cycles");
		$display("sim failed");
		$finish;
	end

endmodule

/* tb/stim_input.txt */
// ir_p1 ir_p2 house_p1 house_p2 two_player leaderboard get_ready hold
// expected_p1 expected_p2 (decimal digits) expected_phase, all hex
0000 0000 0 1 1 0 0 28 0000 0000 0
9000 9000 0 1 1 0 0 30 0000 0000 1
0000 0000 0 1 1 0 0 30 0000 0000 2
9000 a000 0 1 1 0 0 28 0010 0010 2
ffff ffff 0 1 1 0 0 28 0010 0010 2
0000 7fff 0 1 1 0 0 1 0010 0010 2
8000 8000 0 1 1 0 0 28 0020 0020 2
0000 0000 0 1 0 0 0 1 0020 0020 2
c000 c000 0 1 0 0 0 28 0030 0020 2
0000 0000 0 1 1 0 0 1 0030 0020 2
9000 0000 0 1 1 0 0 28 0040 0020 2
0000 0000 0 1 1 1 0 1 0040 0020 4
0000 0000 0 1 1 0 0 28 0040 0020 4
0000 0000 0 1 1 0 1 1 0000 0000 1
0000 0000 0 1 1 0 0 28 0000 0000 1
0000 0000 0 1 1 0 0 81f 0000 0000 3
9000 9000 0 1 1 0 0 20 0000 0000 3
0000 0000 0 1 1 0 0 28 0000 0000 4
0000 0000 0 1 1 0 0 65c5f 0000 0000 4
0000 0000 0 1 1 0 1 1 0000 0000 1
0000 0000 0 1 1 0 0 40 0000 0000 2
9000 9000 2 3 1 0 0 400 0010 0010 2
0000 0000 2 3 1 0 0 28 0010 0010 2

/* project.f */
rtl/game_pkg.sv
rtl/video_pkg.sv
rtl/score_calc.sv
rtl/score_to_digits.sv
rtl/screen_timer.sv
rtl/vga_timing.sv
rtl/pixel_painter.sv
rtl/graphics.sv
tb/graphics_properties.sv
tb/graphics_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module graphics_tb -f project.f || exit 1
out=$(./obj_dir/Vgraphics_tb)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1
